// ==== Bender.yml ====
package:
  name: eg_gen

sources:
  - files:
      - hdl/eg_pkg.sv
      - hdl/eg_delay.sv
      - hdl/eg_slot_timer.sv
      - hdl/eg_regs.sv
      - hdl/eg_env.sv
      - hdl/eg_top.sv
  - target: test
    files:
      - sim/tb_clk.sv
      - sim/tb_eg.sv

// ==== flist.f ====
hdl/eg_pkg.sv
hdl/eg_delay.sv
hdl/eg_slot_timer.sv
hdl/eg_regs.sv
hdl/eg_env.sv
hdl/eg_top.sv
sim/tb_clk.sv
sim/tb_eg.sv

// ==== hdl/eg_delay.sv ====
module eg_delay #(
	parameter type T         = logic,
	parameter int  DEPTH     = 2,
	parameter T    RESET_VAL = '0
) (
	input  logic clk,
	input  logic rst,
	input  T     din,
	output T     dout
);

	T stage [DEPTH];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage[i] <= RESET_VAL;
			end
		end else begin
			stage[0] <= din;
			for (int i = 1; i < DEPTH; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	assign dout = stage[DEPTH-1];

endmodule

// ==== hdl/eg_env.sv ====
module eg_env #(
	parameter int N_SLOTS = 32
) (
	input  logic                        clk,
	input  logic                        rst,
	input  eg_pkg::eg_cfg_t             rd_cfg,
	input  logic [eg_pkg::SLOT_W-1:0]   slot_idx,
	input  logic [eg_pkg::EG_CNT_W-1:0] eg_cnt,
	input  logic [eg_pkg::AM_W-1:0]     am,
	output eg_pkg::eg_out_t             result,
	output logic                        result_valid
);
	import eg_pkg::*;

	localparam int PIPE_ST = 3; // state registers ahead of the ring
	localparam int OUT_LAT = 8; // slot_idx to result
	localparam eg_slot_state_t ST_IDLE = '{phase: PH_RELEASE, level: LEVEL_MAX, key_on: 1'b0};

	eg_slot_state_t st_ring, st1, st2, st3;
	eg_cfg_t        cfg1, cfg2, cfg3;
	logic           key_on_now, key_off_now;
	logic [4:0]     d1_level;
	eg_phase_t      phase0;
	logic [4:0]     rate0, rate1, rate2;
	logic           ar_off1, ar_off2;
	logic [3:0]     sh;
	logic [EG_CNT_W-1:0] cnt_sh;
	logic [2:0]     cnt_sel;
	logic [7:0]     pat;
	logic           step1, step2, cnt_hist, sum_up1, sum_up2;
	logic [8:0]     ar_sum0;
	logic [9:0]     ar_sum, ar_res;
	logic [3:0]     dec_step;
	logic [10:0]    dec_sum;
	logic [9:0]     level_nxt;
	logic [8:0]     am_fin, am4, am5;
	logic [9:0]     lvl4;
	logic [6:0]     tl4;
	logic [10:0]    part5;
	logic [11:0]    sum6;
	logic [9:0]     atten7;
	logic [SLOT_W:0] tag_q; // valid bit over slot number

	// phase and rate from the circulating state
	always_comb begin
		key_on_now  = rd_cfg.key_on && !st_ring.key_on;
		key_off_now = !rd_cfg.key_on && st_ring.key_on;
		d1_level    = (rd_cfg.sl == 4'd15) ? 5'd16 : {1'b0, rd_cfg.sl};
		phase0      = st_ring.phase;
		rate0       = {rd_cfg.rr, 1'b1};
		if (key_off_now) begin
			phase0 = PH_RELEASE;
		end else if (key_on_now) begin
			phase0 = PH_ATTACK;
			rate0  = rd_cfg.ar;
		end else begin
			case (st_ring.phase)
				PH_ATTACK: begin
					phase0 = (st_ring.level == '0) ? PH_DECAY1 : PH_ATTACK;
					rate0  = (st_ring.level == '0) ? rd_cfg.d1r : rd_cfg.ar;
				end
				PH_DECAY1: begin
					phase0 = (st_ring.level[9:5] >= d1_level) ? PH_DECAY2 : PH_DECAY1;
					rate0  = (st_ring.level[9:5] >= d1_level) ? rd_cfg.d2r : rd_cfg.d1r;
				end
				PH_DECAY2: rate0 = rd_cfg.d2r;
				default:   rate0 = {rd_cfg.rr, 1'b1};
			endcase
		end
	end

	// counter field and step pattern, both picked by rate
	always_comb begin
		if (st1.phase == PH_ATTACK) begin
			sh = (rate1[4:1] < 4'd11) ? 4'd11 - rate1[4:1] : 4'd0;
		end else begin
			sh = (rate1[4:1] < 4'd12) ? 4'd12 - rate1[4:1] : 4'd0;
		end
		cnt_sh  = eg_cnt >> sh;
		cnt_sel = cnt_sh[2:0];
		if (rate1[4:3] == 2'b11) begin
			if (rate1[4:1] == 4'hf && st1.phase == PH_ATTACK)
				pat = 8'b11111111; // fastest attack
			else
				pat = rate1[0] ? 8'b10101010 : 8'b00000000;
		end else begin
			if (rate1[4:1] == 4'h0 && st1.phase != PH_ATTACK)
				pat = 8'b11111110; // slowest decay
			else
				pat = rate1[0] ? 8'b11101110 : 8'b10101010;
		end
		step1   = (rate1 == '0) ? 1'b0 : pat[cnt_sel];
		sum_up1 = cnt_sel[0] != cnt_hist;
	end

	// level update
	always_comb begin
		case (rate2[4:1])
			4'b1101:          ar_sum0 = {2'b0, st2.level[9:3]} + 9'd1;
			4'b1110, 4'b1111: ar_sum0 = {1'b0, st2.level[9:2]} + 9'd1;
			default:          ar_sum0 = {3'b0, st2.level[9:4]} + 9'd1;
		endcase
		if (rate2[4:3] == 2'b11)
			ar_sum = step2 ? {ar_sum0, 1'b0} : {1'b0, ar_sum0};
		else
			ar_sum = step2 ? {1'b0, ar_sum0} : 10'd0;
		ar_res = (ar_sum < st2.level) ? st2.level - ar_sum : 10'd0;
		case (rate2[4:1])
			4'b1100: dec_step = {2'b0, step2, ~step2};
			4'b1101: dec_step = {1'b0, step2, ~step2, 1'b0};
			4'b1110: dec_step = {step2, ~step2, 2'b0};
			4'b1111: dec_step = 4'd8;
			default: dec_step = {2'b0, step2, 1'b0};
		endcase
		dec_sum   = {1'b0, st2.level} + {7'b0, dec_step};
		level_nxt = st2.level;
		if (ar_off2) begin
			level_nxt = '0;
		end else if (st2.phase == PH_ATTACK) begin
			if (sum_up2 && st2.level != '0)
				level_nxt = (rate2 == 5'd31) ? 10'd0 : ar_res;
		end else if (sum_up2) begin
			level_nxt = (dec_sum > {1'b0, LEVEL_MAX}) ? LEVEL_MAX : dec_sum[9:0];
		end
	end

	// modulation depth
	always_comb begin
		if (!cfg3.amen) begin
			am_fin = '0;
		end else begin
			case (cfg3.ams)
				2'd1:    am_fin = {2'b0, am};
				2'd2:    am_fin = {1'b0, am, 1'b0};
				2'd3:    am_fin = {am, 2'b0};
				default: am_fin = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			st1     <= ST_IDLE;
			st2     <= ST_IDLE;
			st3     <= ST_IDLE;
			ar_off1 <= 1'b0;
			ar_off2 <= 1'b0;
			sum_up2 <= 1'b0;
		end else begin
			st1     <= '{phase: phase0, level: st_ring.level, key_on: rd_cfg.key_on};
			ar_off1 <= key_on_now && (rd_cfg.ar == 5'd31);
			st2     <= st1;
			ar_off2 <= ar_off1;
			sum_up2 <= sum_up1;
			st3     <= '{phase: st2.phase, level: level_nxt, key_on: st2.key_on};
		end
	end

	always_ff @(posedge clk) begin
		rate1  <= rate0;
		rate2  <= rate1;
		step2  <= step1;
		cfg1   <= rd_cfg;
		cfg2   <= cfg1;
		cfg3   <= cfg2;
		lvl4   <= st3.level;
		tl4    <= cfg3.tl;
		am4    <= am_fin;
		part5  <= {1'b0, lvl4} + {1'b0, tl4, 3'b0};
		am5    <= am4;
		sum6   <= {1'b0, part5} + {2'b0, am5, 1'b0};
		atten7 <= (sum6[11:10] != 2'b0) ? LEVEL_MAX : sum6[9:0];
	end

	eg_delay #(.T(eg_slot_state_t), .DEPTH(N_SLOTS - PIPE_ST), .RESET_VAL(ST_IDLE)) u_state_ring (
		.clk  (clk),
		.rst  (rst),
		.din  (st3),
		.dout (st_ring)
	);

	eg_delay #(.T(logic), .DEPTH(N_SLOTS), .RESET_VAL(1'b0)) u_cnt_hist (
		.clk  (clk),
		.rst  (rst),
		.din  (cnt_sel[0]),
		.dout (cnt_hist)
	);

	eg_delay #(.T(logic [SLOT_W:0]), .DEPTH(OUT_LAT), .RESET_VAL('0)) u_slot_tag (
		.clk  (clk),
		.rst  (rst),
		.din  ({1'b1, slot_idx}),
		.dout (tag_q)
	);

	assign result       = '{slot: tag_q[SLOT_W-1:0], atten: atten7};
	assign result_valid = tag_q[SLOT_W];

endmodule

// ==== hdl/eg_pkg.sv ====
package eg_pkg;

	localparam int SLOT_W   = 5;
	localparam int LEVEL_W  = 10;
	localparam int EG_CNT_W = 15;
	localparam int AM_W     = 7;

	localparam logic [LEVEL_W-1:0] LEVEL_MAX = 10'd1023; // full attenuation

	typedef enum logic [1:0] {
		PH_ATTACK  = 2'd0,
		PH_DECAY1  = 2'd1,
		PH_DECAY2  = 2'd2,
		PH_RELEASE = 2'd3
	} eg_phase_t;

	// one slot's register record
	typedef struct packed {
		logic [4:0] ar;
		logic [4:0] d1r;
		logic [4:0] d2r;
		logic [3:0] rr;
		logic [3:0] sl;     // 15 acts as 16
		logic [6:0] tl;
		logic [1:0] ams;
		logic       amen;
		logic       key_on;
	} eg_cfg_t;

	typedef struct packed {
		eg_phase_t          phase;
		logic [LEVEL_W-1:0] level;
		logic               key_on; // as seen on the last pass
	} eg_slot_state_t;

	typedef struct packed {
		logic [SLOT_W-1:0]  slot;
		logic [LEVEL_W-1:0] atten;
	} eg_out_t;

endpackage

// ==== hdl/eg_regs.sv ====
module eg_regs #(
	parameter int N_SLOTS = 32
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      cfg_we,
	input  logic [eg_pkg::SLOT_W-1:0] cfg_slot,
	input  eg_pkg::eg_cfg_t           cfg_data,
	input  logic [eg_pkg::SLOT_W-1:0] slot_idx,
	output eg_pkg::eg_cfg_t           rd_cfg
);
	import eg_pkg::*;

	eg_cfg_t cfg_mem [N_SLOTS];
	logic    wr_ok;  // slot exists
	logic    wr_hit; // writing the slot read this cycle

	assign wr_ok  = cfg_we && (int'(cfg_slot) < N_SLOTS);
	assign wr_hit = wr_ok && (cfg_slot == slot_idx);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < N_SLOTS; i++) begin
				cfg_mem[i] <= '0;
			end
		end else if (wr_ok) begin
			cfg_mem[cfg_slot] <= cfg_data;
		end
	end

	// read in slot order, one cycle behind slot_idx
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_cfg <= '0;
		end else if (wr_hit) begin
			rd_cfg <= cfg_data; // new record seen at once
		end else begin
			rd_cfg <= cfg_mem[slot_idx];
		end
	end

endmodule

// ==== hdl/eg_slot_timer.sv ====
module eg_slot_timer #(
	parameter int N_SLOTS = 32
) (
	input  logic                        clk,
	input  logic                        rst,
	output logic [eg_pkg::SLOT_W-1:0]   slot_idx,
	output logic [eg_pkg::EG_CNT_W-1:0] eg_cnt
);
	import eg_pkg::*;

	logic       round; // last slot, wraps next
	logic [1:0] div3;

	assign round = (slot_idx == SLOT_W'(N_SLOTS - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_idx <= '0;
		end else begin
			slot_idx <= round ? '0 : slot_idx + 1'b1;
		end
	end

	// envelope counter steps once every three rounds
	always_ff @(posedge clk) begin
		if (rst) begin
			div3   <= '0;
			eg_cnt <= '0;
		end else if (round) begin
			if (div3 == 2'd2) begin
				div3   <= '0;
				eg_cnt <= eg_cnt + 1'b1;
			end else begin
				div3 <= div3 + 1'b1;
			end
		end
	end

endmodule

// ==== hdl/eg_top.sv ====
module eg_top #(
	parameter int N_SLOTS = 32
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      cfg_we,
	input  logic [eg_pkg::SLOT_W-1:0] cfg_slot,
	input  eg_pkg::eg_cfg_t           cfg_data,
	input  logic [eg_pkg::AM_W-1:0]   am,
	output eg_pkg::eg_out_t           result,
	output logic                      result_valid
);
	import eg_pkg::*;

	logic [SLOT_W-1:0]   slot_idx;
	logic [EG_CNT_W-1:0] eg_cnt;
	eg_cfg_t             rd_cfg; // one cycle behind slot_idx

	eg_slot_timer #(.N_SLOTS(N_SLOTS)) u_timer (
		.clk      (clk),
		.rst      (rst),
		.slot_idx (slot_idx),
		.eg_cnt   (eg_cnt)
	);

	eg_regs #(.N_SLOTS(N_SLOTS)) u_regs (
		.clk      (clk),
		.rst      (rst),
		.cfg_we   (cfg_we),
		.cfg_slot (cfg_slot),
		.cfg_data (cfg_data),
		.slot_idx (slot_idx),
		.rd_cfg   (rd_cfg)
	);

	eg_env #(.N_SLOTS(N_SLOTS)) u_env (
		.clk          (clk),
		.rst          (rst),
		.rd_cfg       (rd_cfg),
		.slot_idx     (slot_idx),
		.eg_cnt       (eg_cnt),
		.am           (am),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule

// ==== sim/tb_clk.sv ====
module tb_clk #(
	parameter real PERIOD     = 10.0,
	parameter int  RST_CYCLES = 16
) (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== sim/tb_eg.sv ====
module tb_eg;
	timeunit 1ns;
	timeprecision 100ps;
	import eg_pkg::*;

	localparam int N_SLOTS = 32;
	localparam int N_TESTS = 5;
	// release at rate 31 steps 8 per three rounds, the longest wait
	localparam int RELEASE_ROUNDS = 3 * (1024 / 8);
	localparam int MAX_CYCLES     = (60 * N_TESTS + RELEASE_ROUNDS) * N_SLOTS + 200;

	logic              clk, rst;
	logic              cfg_we;
	logic [SLOT_W-1:0] cfg_slot;
	eg_cfg_t           cfg_data;
	logic [AM_W-1:0]   am;
	eg_out_t           result;
	logic              result_valid;

	logic [LEVEL_W-1:0] exp_val  [N_SLOTS]; // value a settled slot must show
	logic [LEVEL_W-1:0] last_val [N_SLOTS];
	logic               busy     [N_SLOTS]; // slot in transition, no fixed value
	logic               rise_mon [N_SLOTS]; // results may not decrease
	int                 seen     [N_SLOTS];
	int                 value_errs, other_errs, cycles, prev_slot;
	logic               have_prev;
	logic [31:0]        rng_state;
	string              test_name;

	tb_clk #(.PERIOD(10.0), .RST_CYCLES(16)) u_clk (.clk(clk), .rst(rst));

	eg_top #(.N_SLOTS(N_SLOTS)) u_dut (
		.clk          (clk),
		.rst          (rst),
		.cfg_we       (cfg_we),
		.cfg_slot     (cfg_slot),
		.cfg_data     (cfg_data),
		.am           (am),
		.result       (result),
		.result_valid (result_valid)
	);

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// level + tl*8 + 2*scaled am, clipped at full attenuation
	function automatic int atten_expect(int level, int tl, int am_v, int ams, bit amen);
		int mod_v;
		int sum;
		mod_v = 0;
		if (amen && ams != 0)
			mod_v = am_v << (ams - 1);
		sum = level + tl * 8 + 2 * mod_v;
		return (sum > int'(LEVEL_MAX)) ? int'(LEVEL_MAX) : sum;
	endfunction

	task automatic write_cfg(input int slot, input eg_cfg_t c, input logic [AM_W-1:0] am_v);
		@(posedge clk);
		cfg_we   <= 1'b1;
		cfg_slot <= SLOT_W'(slot);
		cfg_data <= c;
		am       <= am_v;
		@(posedge clk);
		cfg_we   <= 1'b0;
	endtask

	task automatic wait_results(input int slot, input int n);
		int target;
		target = seen[slot] + n;
		while (seen[slot] < target) @(posedge clk);
	endtask

	// results stream every cycle in slot order
	assert property (@(posedge clk) disable iff (rst) result_valid |=> result_valid)
		else begin
			other_errs++;
			$display("result_valid dropped after the pipeline had filled");
		end

	assert property (@(posedge clk) rst |=> !result_valid)
		else begin
			other_errs++;
			$display("result_valid was high right after a reset cycle");
		end

	always @(negedge clk) begin
		int s;
		if (!rst && result_valid) begin
			s = int'(result.slot);
			if (have_prev) begin
				assert (s == (prev_slot + 1) % N_SLOTS) else begin
					value_errs++;
					$display("CHECK FAILED test=%s slot_order expected=%0d actual=%0d",
						test_name, (prev_slot + 1) % N_SLOTS, s);
				end
			end
			if (!busy[s]) begin
				assert (result.atten == exp_val[s]) else begin
					value_errs++;
					$display("CHECK FAILED test=%s slot=%0d expected=%0d actual=%0d",
						test_name, s, exp_val[s], result.atten);
				end
			end
			if (rise_mon[s]) begin
				assert (result.atten >= last_val[s]) else begin
					value_errs++;
					$display("CHECK FAILED test=%s slot=%0d expected>=%0d actual=%0d",
						test_name, s, last_val[s], result.atten);
				end
			end
			last_val[s] = result.atten;
			seen[s]     = seen[s] + 1;
			prev_slot   = s;
			have_prev   = 1'b1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout in test %s after %0d cycles", test_name, cycles);
			$display("errors: value=%0d other=%0d", value_errs, other_errs);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin
		int          a, b, lvl, tl, ams, v;
		logic [31:0] r;
		logic [6:0]  am_v;
		eg_cfg_t     c;
		cfg_we    = 1'b0;
		cfg_slot  = '0;
		cfg_data  = '0;
		am        = '0;
		rng_state = 32'h25f0;
		value_errs = 0;
		other_errs = 0;
		cycles     = 0;
		prev_slot  = 0;
		have_prev  = 1'b0;
		for (int i = 0; i < N_SLOTS; i++) begin
			exp_val[i]  = LEVEL_MAX;
			last_val[i] = LEVEL_MAX;
			busy[i]     = 1'b0;
			rise_mon[i] = 1'b0;
			seen[i]     = 0;
		end

		test_name = "idle";
		wait_results(N_SLOTS - 1, 3);
		for (int i = 0; i < N_SLOTS; i++) begin
			if (seen[i] < 2) begin
				other_errs++;
				$display("slot %0d produced no results after reset", i);
			end
		end

		test_name = "instant_attack";
		r  = lcg_next();
		a  = int'(r[28:24]) % N_SLOTS;
		tl = int'(r[22:16]);
		c  = '0;
		c.ar     = 5'd31;
		c.tl     = 7'(tl);
		c.key_on = 1'b1;
		busy[a] = 1'b1;
		write_cfg(a, c, '0);
		wait_results(a, 2);
		exp_val[a] = 10'(atten_expect(0, tl, 0, 0, 1'b0));
		busy[a] = 1'b0;
		wait_results(a, 4);

		test_name = "output_sum";
		for (int k = 0; k < 4; k++) begin
			r    = lcg_next();
			tl   = (k == 3) ? 127 : int'(r[30:24]);
			am_v = r[22:16];
			ams  = (k == 3) ? 3 : int'(r[13:12]);
			if (k == 3)
				am_v = am_v | 7'h40; // enough depth to clip
			c.tl   = 7'(tl);
			c.ams  = 2'(ams);
			c.amen = 1'b1;
			busy[a] = 1'b1;
			write_cfg(a, c, am_v);
			wait_results(a, 2);
			exp_val[a] = 10'(atten_expect(0, tl, int'(am_v), ams, 1'b1));
			busy[a] = 1'b0;
			wait_results(a, 3);
		end

		test_name = "sustain";
		r   = lcg_next();
		b   = int'(r[28:24]) % N_SLOTS;
		if (b == a)
			b = (a + 1) % N_SLOTS;
		lvl = 1 + int'(r[17:16]);
		c   = '0;
		c.ar     = 5'd31;
		c.d1r    = 5'd31;
		c.sl     = 4'(lvl);
		c.key_on = 1'b1;
		busy[b] = 1'b1;
		write_cfg(b, c, am);
		while (last_val[b] == LEVEL_MAX) @(posedge clk);
		rise_mon[b] = 1'b1;
		while (int'(last_val[b]) < lvl * 32) @(posedge clk);
		wait_results(b, 1);
		v = int'(last_val[b]);
		assert (v >= lvl * 32 && v <= lvl * 32 + 7) else begin
			value_errs++;
			$display("CHECK FAILED test=%s slot=%0d expected=%0d..%0d actual=%0d",
				test_name, b, lvl * 32, lvl * 32 + 7, v);
		end
		exp_val[b] = 10'(v);
		busy[b] = 1'b0;
		wait_results(b, 10); // spans several counter steps

		test_name = "release";
		c.key_on = 1'b0;
		c.rr     = 4'd15;
		busy[b] = 1'b1;
		write_cfg(b, c, am);
		while (last_val[b] != LEVEL_MAX) @(posedge clk);
		exp_val[b] = LEVEL_MAX;
		busy[b] = 1'b0;
		wait_results(b, 4);

		$display("errors: value=%0d other=%0d", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule
